// File: source/nnFixedPkg.sv
package nnFixedPkg;

	// ==========================================================================
	// Q8.8 number format
	// ==========================================================================

	localparam int DATA_WIDTH = 16; // activations, weights and biases
	localparam int FRAC_BITS = 8; // fraction bits of every word
	localparam int PROD_WIDTH = 2 * DATA_WIDTH; // products keep every bit

	// fifteen full products and the shifted bias fit with room to spare
	localparam int ACC_WIDTH = 40;

	// the ReLU output saturates at the largest positive word
	localparam int MAX_ACT = (1 << (DATA_WIDTH - 1)) - 1;

	// ==========================================================================
	// signed word types
	// ==========================================================================

	typedef logic signed [DATA_WIDTH-1:0] fixWord;
	typedef logic signed [PROD_WIDTH-1:0] prodWord;
	typedef logic signed [ACC_WIDTH-1:0] accWord;

endpackage

// File: source/nnLayerPkg.sv
package nnLayerPkg;

	import nnFixedPkg::*;

	// ==========================================================================
	// layer geometry
	// ==========================================================================

	localparam int IN_COUNT = 15; // activations per neuron
	localparam int NEURON_COUNT = 8;
	localparam int NEURON_IDX_WIDTH = $clog2(NEURON_COUNT);
	localparam int IN_IDX_WIDTH = $clog2(IN_COUNT);

	// ==========================================================================
	// coefficient address map
	// ==========================================================================

	// weights are packed neuron by neuron with IN_COUNT entries for each
	localparam int WEIGHT_COUNT = NEURON_COUNT * IN_COUNT;
	localparam int COEFF_ADDR_WIDTH = 7; // 120 weights plus 8 biases fill all 128
	localparam int BIAS_BASE = WEIGHT_COUNT; // first bias address

	// ==========================================================================
	// vector and table types
	// ==========================================================================

	typedef fixWord actVector [IN_COUNT];
	typedef fixWord outVector [NEURON_COUNT];
	typedef fixWord weightTable [NEURON_COUNT][IN_COUNT];
	typedef fixWord biasTable [NEURON_COUNT];

endpackage

// File: source/nnCoeffRegs.sv
`timescale 1ns/1ps

module nnCoeffRegs
	import nnFixedPkg::*;
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic cfgWrite,
	input logic [COEFF_ADDR_WIDTH-1:0] cfgAddr,
	input fixWord cfgWriteData,
	output fixWord cfgReadData,
	output weightTable weights,
	output biasTable biases
);

	logic isBias;
	logic [NEURON_IDX_WIDTH-1:0] weightNeuron;
	logic [IN_IDX_WIDTH-1:0] weightInput;
	logic [NEURON_IDX_WIDTH-1:0] biasNeuron;

	// ==========================================================================
	// address decode
	// ==========================================================================

	assign isBias = (cfgAddr >= COEFF_ADDR_WIDTH'(BIAS_BASE));

	// only meaningful below BIAS_BASE, where the quotient stays under NEURON_COUNT
	assign weightNeuron = NEURON_IDX_WIDTH'(cfgAddr / COEFF_ADDR_WIDTH'(IN_COUNT));
	assign weightInput = IN_IDX_WIDTH'(cfgAddr % COEFF_ADDR_WIDTH'(IN_COUNT));

	assign biasNeuron = NEURON_IDX_WIDTH'(cfgAddr - COEFF_ADDR_WIDTH'(BIAS_BASE));

	// ==========================================================================
	// coefficient storage
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int n = 0; n < NEURON_COUNT; n++)
			begin
				biases[n] <= '0;
				for (int i = 0; i < IN_COUNT; i++)
				begin
					weights[n][i] <= '0;
				end
			end
		end
		else if (cfgWrite)
		begin
			if (isBias)
			begin
				biases[biasNeuron] <= cfgWriteData;
			end
			else
			begin
				weights[weightNeuron][weightInput] <= cfgWriteData;
			end
		end
	end

	// readback follows cfgAddr without a register stage
	always_comb
	begin
		if (isBias)
		begin
			cfgReadData = biases[biasNeuron];
		end
		else
		begin
			cfgReadData = weights[weightNeuron][weightInput];
		end
	end

	writeDataKnown: assert property (@(posedge clk) disable iff (reset)
		cfgWrite |-> !$isunknown(cfgWriteData))
		else $error("coefficient write with unknown data at address %0d", cfgAddr);

endmodule

// File: source/nnNeuron.sv
`timescale 1ns/1ps

module nnNeuron
	import nnFixedPkg::*;
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic captureEn,
	input actVector acts,
	input fixWord weights [IN_COUNT],
	input fixWord bias,
	output fixWord result
);

	actVector actReg; // activations held for the accumulate stage
	accWord accReg;
	accWord sumNext;
	accWord shifted;
	fixWord clamped;

	// ==========================================================================
	// multiply-accumulate
	// ==========================================================================

	// bias is moved up to the product scale so that one shift rescales everything
	always_comb
	begin
		prodWord prod;
		sumNext = accWord'(bias) <<< FRAC_BITS;
		for (int i = 0; i < IN_COUNT; i++)
		begin
			prod = actReg[i] * weights[i]; // full 32-bit product
			sumNext = sumNext + accWord'(prod);
		end
	end

	// ==========================================================================
	// rescale, saturate and ReLU
	// ==========================================================================

	assign shifted = accReg >>> FRAC_BITS; // rounds toward minus infinity

	always_comb
	begin
		if (shifted < 0)
		begin
			clamped = '0;
		end
		else if (shifted > MAX_ACT)
		begin
			clamped = fixWord'(MAX_ACT);
		end
		else
		begin
			clamped = fixWord'(shifted);
		end
	end

	// ==========================================================================
	// pipeline registers
	// ==========================================================================

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '{default: '0};
			accReg <= '0;
			result <= '0;
		end
		else
		begin
			if (captureEn)
			begin
				actReg <= acts;
			end
			accReg <= sumNext; // weights are taken as they stand at this stage
			result <= clamped;
		end
	end

	resultNonNegative: assert property (@(posedge clk) disable iff (reset)
		!result[DATA_WIDTH-1])
		else $error("neuron result %0d has its sign bit set", result);

endmodule

// File: source/nnLayer.sv
`timescale 1ns/1ps

module nnLayer
	import nnFixedPkg::*;
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,
	input logic inStrobe,
	input actVector inVector,
	input weightTable weights,
	input biasTable biases,
	output logic outStrobe,
	output nnLayerPkg::outVector outVector
);

	logic captureValid; // vector sits in the neuron input registers
	logic accValid; // accumulators hold a finished sum
	wire fixWord neuronResult [NEURON_COUNT];

	// ==========================================================================
	// neurons
	// ==========================================================================

	for (genvar n = 0; n < NEURON_COUNT; n++)
	begin : genNeuron
		nnNeuron neuron_inst (
			.clk(clk),
			.reset(reset),
			.captureEn(inStrobe),
			.acts(inVector),
			.weights(weights[n]),
			.bias(biases[n]),
			.result(neuronResult[n])
		);
	end

	assign outVector = neuronResult;

	// ==========================================================================
	// strobe pipeline
	// ==========================================================================

	// runs in step with the capture, accumulate and result registers
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			captureValid <= 1'b0;
			accValid <= 1'b0;
			outStrobe <= 1'b0;
		end
		else
		begin
			captureValid <= inStrobe;
			accValid <= captureValid;
			outStrobe <= accValid;
		end
	end

	// outStrobe is registered two edges after the edge that sampled inStrobe
	strobeHasSource: assert property (@(posedge clk) disable iff (reset)
		outStrobe |-> $past(inStrobe, 3))
		else $error("outStrobe without a matching inStrobe");

endmodule

// File: source/nnDenseTop.sv
`timescale 1ns/1ps

module nnDenseTop
	import nnFixedPkg::*;
	import nnLayerPkg::*;
(
	input logic clk,
	input logic reset,

	// coefficient access
	input logic cfgWrite,
	input logic [COEFF_ADDR_WIDTH-1:0] cfgAddr,
	input fixWord cfgWriteData,
	output fixWord cfgReadData,

	// activation path
	input logic inStrobe,
	input actVector inVector,
	output logic outStrobe,
	output nnLayerPkg::outVector outVector
);

	weightTable coeffWeights;
	biasTable coeffBiases;

	// ==========================================================================
	// coefficient registers
	// ==========================================================================

	nnCoeffRegs nnCoeffRegs_inst (
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgWriteData(cfgWriteData),
		.cfgReadData(cfgReadData),
		.weights(coeffWeights),
		.biases(coeffBiases)
	);

	// ==========================================================================
	// dense layer
	// ==========================================================================

	nnLayer nnLayer_inst (
		.clk(clk),
		.reset(reset),
		.inStrobe(inStrobe),
		.inVector(inVector),
		.weights(coeffWeights),
		.biases(coeffBiases),
		.outStrobe(outStrobe),
		.outVector(outVector)
	);

endmodule

// File: include/nnTbRef.svh
`ifndef NN_TB_REF_SVH
`define NN_TB_REF_SVH

// ==========================================================================
// reference model of the dense layer
// ==========================================================================

// Q8.8 neuron rule worked out in 64-bit arithmetic
function automatic fixWord computeNeuron(input actVector acts, input fixWord w [IN_COUNT],
	input fixWord b);
	longint sum;
	longint shifted;
	sum = longint'(b) <<< FRAC_BITS;
	for (int i = 0; i < IN_COUNT; i++)
	begin
		sum = sum + longint'(acts[i]) * longint'(w[i]);
	end
	shifted = sum >>> FRAC_BITS; // arithmetic shift rounds toward minus infinity
	if (shifted < 0)
		return '0;
	if (shifted > MAX_ACT)
		return fixWord'(MAX_ACT);
	return fixWord'(shifted);
endfunction

function automatic nnLayerPkg::outVector expectedLayer(input actVector acts,
	input weightTable w, input biasTable b);
	nnLayerPkg::outVector res;
	for (int n = 0; n < NEURON_COUNT; n++)
	begin
		res[n] = computeNeuron(acts, w[n], b[n]);
	end
	return res;
endfunction

// ==========================================================================
// shadow copy of the coefficient map
// ==========================================================================

function automatic void recordCoeff(inout weightTable w, inout biasTable b,
	input int addr, input fixWord data);
	if (addr >= BIAS_BASE)
		b[addr - BIAS_BASE] = data;
	else
		w[addr / IN_COUNT][addr % IN_COUNT] = data;
endfunction

function automatic fixWord lookupCoeff(input weightTable w, input biasTable b, input int addr);
	if (addr >= BIAS_BASE)
		return b[addr - BIAS_BASE];
	return w[addr / IN_COUNT][addr % IN_COUNT];
endfunction

`endif

// File: dv/nnDenseTb.sv
`timescale 1ns/1ps

module nnDenseTb
	import nnFixedPkg::*;
	import nnLayerPkg::*;
();

	typedef enum int {SETUP_CHECK_RESET, SETUP_RANDOM, SETUP_KEEP, SETUP_IDENTITY,
		SETUP_NEGATIVE, SETUP_LARGE} setupKind;

	localparam int TEST_COUNT = 6;
	localparam int CLK_PERIOD = 8;
	localparam int WATCHDOG_NS = (TEST_COUNT * 4 + 128 + 20) * 4 * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic cfgWrite;
	logic [COEFF_ADDR_WIDTH-1:0] cfgAddr;
	fixWord cfgWriteData;
	fixWord cfgReadData;
	logic inStrobe;
	actVector inVector;
	logic outStrobe;
	nnLayerPkg::outVector outValues;

	// stimulus table with one row per test
	string testName [TEST_COUNT];
	setupKind testSetup [TEST_COUNT];
	int testVecCount [TEST_COUNT];
	bit testBackToBack [TEST_COUNT];
	actVector testVecs [TEST_COUNT][4];

	weightTable shadowW; // what the DUT should hold
	biasTable shadowB;
	nnLayerPkg::outVector expVals [8]; // results still in flight
	int expCycle [8];
	int expHead = 0;
	int expTail = 0;
	int cycleCount = 0;
	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;
	string curName = "";
	logic [31:0] rngState = 32'h3196_9115;

	nnDenseTop nnDenseTop_inst (
		.clk(clk),
		.reset(reset),
		.cfgWrite(cfgWrite),
		.cfgAddr(cfgAddr),
		.cfgWriteData(cfgWriteData),
		.cfgReadData(cfgReadData),
		.inStrobe(inStrobe),
		.inVector(inVector),
		.outStrobe(outStrobe),
		.outVector(outValues)
	);

	`include "nnTbRef.svh"

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycleCount <= cycleCount + 1;

	// ==========================================================================
	// helpers
	// ==========================================================================

	function automatic logic [31:0] nextRandom();
		rngState = rngState ^ (rngState << 13);
		rngState = rngState ^ (rngState >> 17);
		rngState = rngState ^ (rngState << 5);
		return rngState;
	endfunction

	// sign-extended random value of the given width
	function automatic fixWord signedRandom(input int bits);
		logic signed [31:0] r;
		r = $signed(nextRandom() << (32 - bits));
		return fixWord'(r >>> (32 - bits));
	endfunction

	task automatic stepCycle();
		@(posedge clk);
		#1;
	endtask

	task automatic applyReset();
		reset = 1'b1;
		stepCycle();
		stepCycle();
		reset = 1'b0;
		shadowW = '{default: '{default: '0}};
		shadowB = '{default: '0};
	endtask

	task automatic writeCoeff(input int addr, input fixWord data);
		cfgWrite = 1'b1;
		cfgAddr = COEFF_ADDR_WIDTH'(addr);
		cfgWriteData = data;
		stepCycle();
		cfgWrite = 1'b0;
		recordCoeff(shadowW, shadowB, addr, data);
	endtask

	task automatic readAllCoeffs();
		fixWord expected;
		for (int a = 0; a < 128; a++)
		begin
			cfgAddr = COEFF_ADDR_WIDTH'(a);
			expected = lookupCoeff(shadowW, shadowB, a);
			@(negedge clk);
			if (cfgReadData !== expected)
			begin
				$display("ERR %s address %0d expected %0d actual %0d", curName, a, expected,
					cfgReadData);
				errorCount++;
			end
			stepCycle();
		end
	endtask

	task automatic loadCoeffs(input setupKind kind);
		for (int n = 0; n < NEURON_COUNT; n++)
		begin
			case (kind)
				SETUP_IDENTITY:
				begin
					writeCoeff(n * IN_COUNT + n, 16'sh0100); // 1.0
					writeCoeff(BIAS_BASE + n, fixWord'(n * 5 + 1));
				end
				SETUP_NEGATIVE:
				begin
					writeCoeff(n * IN_COUNT + n, (n % 2 == 1) ? 16'sh0100 : 16'shFF00);
					writeCoeff(BIAS_BASE + n, (n % 4 == 1) ? 16'shFE00 : 16'sh0010);
				end
				SETUP_LARGE:
				begin
					writeCoeff(n * IN_COUNT, 16'sh7F00); // 127.0
					writeCoeff(n * IN_COUNT + 1, (n % 2 == 0) ? 16'sh7F00 : 16'sh0010);
					writeCoeff(BIAS_BASE + n, fixWord'(n * 256));
				end
				default:
				begin
				end
			endcase
		end
		if (kind == SETUP_RANDOM)
		begin
			for (int a = 0; a < 128; a++)
			begin
				writeCoeff(a, signedRandom(11)); // within +-4.0
			end
			readAllCoeffs();
		end
	endtask

	task automatic checkResetOutputs();
		for (int c = 0; c < 4; c++)
		begin
			@(negedge clk);
			if (outStrobe !== 1'b0)
			begin
				$display("outStrobe is not low after reset in test %s", curName);
				errorCount++;
			end
			for (int n = 0; n < NEURON_COUNT; n++)
			begin
				if (outValues[n] !== '0)
				begin
					$display("ERR %s outVector[%0d] expected 0 actual %0d", curName, n,
						outValues[n]);
					errorCount++;
				end
			end
			stepCycle();
		end
	endtask

	task automatic sendVector(input actVector v);
		inVector = v;
		inStrobe = 1'b1;
		expVals[expTail % 8] = expectedLayer(v, shadowW, shadowB);
		expCycle[expTail % 8] = cycleCount + 3; // out two edges after the sampling edge
		expTail++;
		stepCycle();
		inStrobe = 1'b0;
	endtask

	task automatic drainResults();
		int waited;
		waited = 0;
		while (expHead != expTail && waited < 10)
		begin
			stepCycle();
			waited++;
		end
		if (expHead != expTail)
		begin
			$display("missing outStrobe in test %s, %0d result(s) never arrived", curName,
				expTail - expHead);
			errorCount++;
			expHead = expTail;
		end
	endtask

	task automatic compareVector(input nnLayerPkg::outVector expected);
		for (int n = 0; n < NEURON_COUNT; n++)
		begin
			if (outValues[n] !== expected[n])
			begin
				$display("ERR %s neuron %0d expected %0d actual %0d", curName, n, expected[n],
					outValues[n]);
				errorCount++;
			end
		end
	endtask

	// every outStrobe must match the oldest vector in flight
	always @(negedge clk)
	begin
		if (reset === 1'b0 && outStrobe === 1'b1)
		begin
			if (expHead == expTail)
			begin
				$display("unexpected outStrobe in test %s at cycle %0d", curName, cycleCount);
				errorCount++;
			end
			else
			begin
				if (cycleCount != expCycle[expHead % 8])
				begin
					$display("outStrobe in test %s came at cycle %0d instead of cycle %0d",
						curName, cycleCount, expCycle[expHead % 8]);
					errorCount++;
				end
				compareVector(expVals[expHead % 8]);
				expHead++;
			end
		end
	end

	// ==========================================================================
	// stimulus table
	// ==========================================================================

	task automatic buildTable();
		testName = '{"resetState", "coeffReadback", "backToBack", "weightedSum", "reluClamp",
			"saturation"};
		testSetup = '{SETUP_CHECK_RESET, SETUP_RANDOM, SETUP_KEEP, SETUP_IDENTITY,
			SETUP_NEGATIVE, SETUP_LARGE};
		testVecCount = '{0, 0, 4, 2, 2, 2};
		testBackToBack = '{0, 0, 1, 0, 0, 0};
		for (int t = 0; t < TEST_COUNT; t++)
		begin
			for (int v = 0; v < 4; v++)
			begin
				for (int i = 0; i < IN_COUNT; i++)
				begin
					case (testSetup[t])
						SETUP_KEEP: testVecs[t][v][i] = signedRandom(9);
						SETUP_IDENTITY: testVecs[t][v][i] = fixWord'(nextRandom() & 32'h0FFF);
						SETUP_NEGATIVE: testVecs[t][v][i] = fixWord'(nextRandom() & 32'h03FF);
						SETUP_LARGE: testVecs[t][v][i] = (v == 0) ? 16'sh4000 :
							fixWord'(nextRandom() & 32'h00FF);
						default: testVecs[t][v][i] = '0;
					endcase
				end
			end
		end
	endtask

	// ==========================================================================
	// test sequence
	// ==========================================================================

	initial
	begin
		int errorsBefore;
		reset = 1'b1;
		cfgWrite = 1'b0;
		cfgAddr = '0;
		cfgWriteData = '0;
		inStrobe = 1'b0;
		inVector = '{default: '0};
		buildTable();
		for (int t = 0; t < TEST_COUNT; t++)
		begin
			curName = testName[t];
			errorsBefore = errorCount;
			if (testSetup[t] != SETUP_KEEP)
			begin
				applyReset();
			end
			if (testSetup[t] == SETUP_CHECK_RESET)
			begin
				checkResetOutputs();
				readAllCoeffs();
			end
			loadCoeffs(testSetup[t]);
			for (int v = 0; v < testVecCount[t]; v++)
			begin
				sendVector(testVecs[t][v]);
				if (!testBackToBack[t])
				begin
					drainResults();
				end
			end
			drainResults();
			stepCycle(); // room for a stray strobe to show up
			stepCycle();
			if (errorCount == errorsBefore)
			begin
				passCount++;
				$display("PASS %s", curName);
			end
			else
			begin
				failCount++;
				$display("FAIL %s", curName);
			end
		end
		$display("tests passed %0d, failed %0d", passCount, failCount);
		if (failCount == 0 && errorCount == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns in test %s", WATCHDOG_NS, curName);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

// File: nnDense.f
+incdir+include
source/nnFixedPkg.sv
source/nnLayerPkg.sv
source/nnCoeffRegs.sv
source/nnNeuron.sv
source/nnLayer.sv
source/nnDenseTop.sv
dv/nnDenseTb.sv
